/* Bender.yml */
package:
  name: mem_sys

sources:
  - files:
      - mem_sys_pkg.sv
      - mem_req_if.sv
      - warm_up_ctrl.sv
      - port_arbiter.sv
      - req_fifo.sv
      - wb_master.sv
      - mem_sys_top.sv
  - target: test
    files:
      - tb_wb_mem.sv
      - tb_mem_sys.sv

/* mem_req_if.sv */
`timescale 1ns/1ps

interface mem_req_if;

    import mem_sys_pkg::*;

    logic valid;
    logic ready;
    mem_req_t req;

    // Source holds valid and req until the cycle with ready high.
    modport source (
        output valid,
        output req,
        input ready
    );

    modport sink (
        input valid,
        input req,
        output ready
    );

endinterface

/* mem_sys_pkg.sv */
package mem_sys_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W = 4; // One select per byte lane.

    localparam int NUM_PORTS = 3;
    localparam int PORT_ID_W = $clog2(NUM_PORTS);

    // Lower index wins arbitration.
    localparam int PORT_DATA = 0;
    localparam int PORT_UNCACHED = 1;
    localparam int PORT_INST = 2;

    // Start-up sequence.
    localparam int COLD_CYCLES = 128;
    localparam int COLD_CNT_W = $clog2(COLD_CYCLES);
    localparam int WARM_READS = 3;
    localparam int WARM_CNT_W = $clog2(WARM_READS + 1);

    localparam int QUEUE_DEPTH = 4;

    typedef logic [PORT_ID_W-1:0] port_id_t;

    // One single-word bus transfer and the port that asked for it.
    typedef struct packed {
        logic we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [SEL_W-1:0] sel;
        port_id_t port;
    } mem_req_t;

endpackage

/* mem_sys_top.sv */
`timescale 1ns/1ps

module mem_sys_top (
    input logic Clk,
    input logic Myreset,

    // Requester ports.
    input logic [mem_sys_pkg::NUM_PORTS-1:0] port_req_i,
    input logic [mem_sys_pkg::NUM_PORTS-1:0] port_we_i,
    input logic [mem_sys_pkg::NUM_PORTS-1:0][mem_sys_pkg::ADDR_W-1:0] port_addr_i,
    input logic [mem_sys_pkg::NUM_PORTS-1:0][mem_sys_pkg::DATA_W-1:0] port_wdata_i,
    input logic [mem_sys_pkg::NUM_PORTS-1:0][mem_sys_pkg::SEL_W-1:0] port_sel_i,
    output logic [mem_sys_pkg::NUM_PORTS-1:0] port_ack_o,
    output logic [mem_sys_pkg::DATA_W-1:0] port_rdata_o,

    // Wishbone classic master.
    output logic wb_cyc_o,
    output logic wb_stb_o,
    output logic wb_we_o,
    output logic [mem_sys_pkg::ADDR_W-1:0] wb_adr_o,
    output logic [mem_sys_pkg::DATA_W-1:0] wb_dat_o,
    output logic [mem_sys_pkg::SEL_W-1:0] wb_sel_o,
    input logic [mem_sys_pkg::DATA_W-1:0] wb_dat_i,
    input logic wb_ack_i
);

    import mem_sys_pkg::*;

    logic serve_en;
    logic cached_open;
    logic warm_read_done;

    mem_req_if arb_q ();
    mem_req_if q_wb ();

    warm_up_ctrl warm_up_ctrl_inst (
        .Clk (Clk),
        .Myreset (Myreset),
        .warm_read_done_i (warm_read_done),
        .serve_en_o (serve_en),
        .cached_open_o (cached_open)
    );

    port_arbiter port_arbiter_inst (
        .Clk (Clk),
        .Myreset (Myreset),
        .port_req_i (port_req_i),
        .port_we_i (port_we_i),
        .port_addr_i (port_addr_i),
        .port_wdata_i (port_wdata_i),
        .port_sel_i (port_sel_i),
        .rsp_ack_i (port_ack_o), // Clears the pending bit.
        .serve_en_i (serve_en),
        .cached_open_i (cached_open),
        .arb_q (arb_q.source)
    );

    req_fifo #(
        .DEPTH (QUEUE_DEPTH)
    ) req_fifo_inst (
        .Clk (Clk),
        .Myreset (Myreset),
        .arb_q (arb_q.sink),
        .q_wb (q_wb.source)
    );

    wb_master wb_master_inst (
        .Clk (Clk),
        .Myreset (Myreset),
        .q_wb (q_wb.sink),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_sel_o (wb_sel_o),
        .port_ack_o (port_ack_o),
        .port_rdata_o (port_rdata_o),
        .warm_read_done_o (warm_read_done)
    );

endmodule

/* port_arbiter.sv */
`timescale 1ns/1ps

module port_arbiter (
    input logic Clk,
    input logic Myreset,
    input logic [mem_sys_pkg::NUM_PORTS-1:0] port_req_i,
    input logic [mem_sys_pkg::NUM_PORTS-1:0] port_we_i,
    input logic [mem_sys_pkg::NUM_PORTS-1:0][mem_sys_pkg::ADDR_W-1:0] port_addr_i,
    input logic [mem_sys_pkg::NUM_PORTS-1:0][mem_sys_pkg::DATA_W-1:0] port_wdata_i,
    input logic [mem_sys_pkg::NUM_PORTS-1:0][mem_sys_pkg::SEL_W-1:0] port_sel_i,
    input logic [mem_sys_pkg::NUM_PORTS-1:0] rsp_ack_i,
    input logic serve_en_i,
    input logic cached_open_i,
    mem_req_if.source arb_q
);

    import mem_sys_pkg::*;

    logic [NUM_PORTS-1:0] pending;
    logic [NUM_PORTS-1:0] allowed;
    logic [NUM_PORTS-1:0] in_flight;
    logic [NUM_PORTS-1:0] cand;
    logic [NUM_PORTS-1:0] push_bit;
    logic grant_vld;
    port_id_t grant_id;
    logic slot_free;
    logic valid_q;
    mem_req_t req_q;

    assign arb_q.valid = valid_q;
    assign arb_q.req = req_q;

    assign slot_free = !valid_q || arb_q.ready;

    always_comb begin
        allowed = '0;
        if (serve_en_i) begin
            if (cached_open_i) begin
                allowed = '1;
            end else begin
                allowed[PORT_UNCACHED] = 1'b1; // Bypass mode during warm-up.
            end
        end
    end

    // The port on the interface is not yet marked pending.
    always_comb begin
        in_flight = '0;
        if (valid_q) begin
            in_flight[req_q.port] = 1'b1;
        end
    end

    assign cand = port_req_i & allowed & ~pending & ~in_flight;

    // Fixed priority, lowest index wins.
    always_comb begin
        grant_vld = 1'b0;
        grant_id = '0;
        for (int p = NUM_PORTS - 1; p >= 0; p--) begin
            if (cand[p]) begin
                grant_vld = 1'b1;
                grant_id = port_id_t'(p);
            end
        end
    end

    assign push_bit = (valid_q && arb_q.ready) ? in_flight : '0;

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            pending <= '0;
            valid_q <= 1'b0;
        end else begin
            pending <= (pending | push_bit) & ~rsp_ack_i;
            if (slot_free) begin
                valid_q <= grant_vld;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (slot_free && grant_vld) begin
            req_q.we <= port_we_i[grant_id];
            req_q.addr <= port_addr_i[grant_id];
            req_q.wdata <= port_wdata_i[grant_id];
            req_q.sel <= port_sel_i[grant_id];
            req_q.port <= grant_id;
        end
    end

endmodule

/* req_fifo.sv */
`timescale 1ns/1ps

module req_fifo #(
    parameter int DEPTH = mem_sys_pkg::QUEUE_DEPTH
) (
    input logic Clk,
    input logic Myreset,
    mem_req_if.sink arb_q,
    mem_req_if.source q_wb
);

    import mem_sys_pkg::*;

    typedef logic [$clog2(DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    mem_req_t mem [DEPTH];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic push;
    logic pop;

    assign arb_q.ready = (count != cnt_t'(DEPTH)); // Low only when full.
    assign q_wb.valid = (count != '0);
    assign q_wb.req = mem[rd_ptr];

    assign push = arb_q.valid && arb_q.ready;
    assign pop = q_wb.valid && q_wb.ready;

    always_ff @(posedge Clk) begin
        if (push) begin
            mem[wr_ptr] <= arb_q.req;
        end
    end

    // Pointers wrap by compare so any depth works.
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count; // Both or neither.
            endcase
        end
    end

endmodule

/* tb.f */
mem_sys_pkg.sv
mem_req_if.sv
warm_up_ctrl.sv
port_arbiter.sv
req_fifo.sv
wb_master.sv
mem_sys_top.sv
tb_wb_mem.sv
tb_mem_sys.sv

/* tb_mem_sys.sv */
`timescale 1ns/1ps

module tb_mem_sys;

    import mem_sys_pkg::*;

    localparam logic [31:0] SEED = 32'hb752_6f60;
    localparam int MEM_WORDS = 256;
    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int MAX_WAIT = 7;
    localparam int RESET_CYCLES = 8;
    localparam int STALL_CYCLES = 12;
    localparam int OPS_PER_PORT = 8;
    localparam int NUM_XFERS = 10 + 3 + NUM_PORTS * OPS_PER_PORT; // Warm-up, rw, priority.
    localparam int TIMEOUT = RESET_CYCLES + COLD_CYCLES + STALL_CYCLES
        + NUM_XFERS * (MAX_WAIT + 10);

    logic Clk;
    logic Myreset;
    logic [NUM_PORTS-1:0] port_req;
    logic [NUM_PORTS-1:0] port_we;
    logic [NUM_PORTS-1:0][ADDR_W-1:0] port_addr;
    logic [NUM_PORTS-1:0][DATA_W-1:0] port_wdata;
    logic [NUM_PORTS-1:0][SEL_W-1:0] port_sel;
    logic [NUM_PORTS-1:0] port_ack_o;
    logic [DATA_W-1:0] port_rdata_o;
    logic wb_cyc_o;
    logic wb_stb_o;
    logic wb_we_o;
    logic [ADDR_W-1:0] wb_adr_o;
    logic [DATA_W-1:0] wb_dat_o;
    logic [SEL_W-1:0] wb_sel_o;
    logic [DATA_W-1:0] wb_dat_i;
    logic wb_ack_i;
    logic stall;
    logic rand_wait;

    integer seed;
    int cycle_cnt;
    int ack_cnt [NUM_PORTS];
    logic [ADDR_W-1:0] bus_log [$];
    logic [DATA_W-1:0] ref_mem [MEM_WORDS];
    logic op_we [NUM_PORTS][OPS_PER_PORT];
    logic [ADDR_W-1:0] op_addr [NUM_PORTS][OPS_PER_PORT];
    logic [DATA_W-1:0] op_wdata [NUM_PORTS][OPS_PER_PORT];
    logic [SEL_W-1:0] op_sel [NUM_PORTS][OPS_PER_PORT];

    mem_sys_top mem_sys_top_inst (
        .Clk (Clk),
        .Myreset (Myreset),
        .port_req_i (port_req),
        .port_we_i (port_we),
        .port_addr_i (port_addr),
        .port_wdata_i (port_wdata),
        .port_sel_i (port_sel),
        .port_ack_o (port_ack_o),
        .port_rdata_o (port_rdata_o),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_sel_o (wb_sel_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i)
    );

    tb_wb_mem #(
        .MEM_WORDS (MEM_WORDS),
        .MAX_WAIT (MAX_WAIT),
        .SEED (SEED)
    ) wb_mem_inst (
        .Clk (Clk),
        .Myreset (Myreset),
        .wb_cyc_i (wb_cyc_o),
        .wb_stb_i (wb_stb_o),
        .wb_we_i (wb_we_o),
        .wb_adr_i (wb_adr_o),
        .wb_dat_i (wb_dat_o),
        .wb_sel_i (wb_sel_o),
        .stall_i (stall),
        .rand_wait_i (rand_wait),
        .wb_dat_o (wb_dat_i),
        .wb_ack_o (wb_ack_i)
    );

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    // Bus order and per-port ack counts.
    always @(negedge Clk) begin
        assert (wb_stb_o == wb_cyc_o) else abort_run("wb_stb_o and wb_cyc_o disagree");
        if (wb_cyc_o && wb_stb_o && wb_ack_i) begin
            bus_log.push_back(wb_adr_o);
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (port_ack_o[p]) begin
                ack_cnt[p] = ack_cnt[p] + 1;
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT) begin
            @(posedge Clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, a port never received its ack", cycle_cnt);
        $display("Test FAILED");
        $fatal(1, "Run stopped by the cycle limit.");
    end

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("ERR %s: expected %h, actual %h", name, exp, act);
        $display("Test FAILED");
        $fatal(1, "Value check failed.");
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "Check failed.");
    endtask

    task automatic clear_ack_counts();
        for (int p = 0; p < NUM_PORTS; p++) begin
            ack_cnt[p] = 0;
        end
    endtask

    function automatic logic [DATA_W-1:0] fill_word(input int idx);
        logic [DATA_W-1:0] a;
        a = DATA_W'(idx) << 2;
        return 32'h5a5a_0000 ^ a ^ (a << 16);
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
        input logic [DATA_W-1:0] wdata, input logic [SEL_W-1:0] sel);
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < SEL_W; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Returns the word a read sees, and records a write.
    function automatic logic [DATA_W-1:0] apply_ref(input logic we,
        input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
        input logic [SEL_W-1:0] sel);
        logic [DATA_W-1:0] old_w;
        old_w = ref_mem[addr[IDX_W+1:2]];
        if (we) begin
            ref_mem[addr[IDX_W+1:2]] = merge_bytes(old_w, wdata, sel);
        end
        return old_w;
    endfunction

    task automatic wait_ack(input int p, input logic is_read, input logic [DATA_W-1:0] exp,
        input string name);
        do begin
            @(negedge Clk);
        end while (!port_ack_o[p]);
        assert (port_ack_o == NUM_PORTS'(1 << p))
            else mismatch({name, " ack"}, 32'(1 << p), 32'(port_ack_o));
        if (is_read) begin
            assert (port_rdata_o == exp) else mismatch(name, exp, port_rdata_o);
        end
        @(posedge Clk);
        port_req[p] <= 1'b0; // Dropped on the cycle after the ack.
    endtask

    task automatic do_access(input int p, input logic we, input logic [ADDR_W-1:0] addr,
        input logic [DATA_W-1:0] wdata, input logic [SEL_W-1:0] sel, input string name);
        logic [DATA_W-1:0] exp;
        exp = apply_ref(we, addr, wdata, sel);
        @(posedge Clk);
        port_req[p] <= 1'b1;
        port_we[p] <= we;
        port_addr[p] <= addr;
        port_wdata[p] <= wdata;
        port_sel[p] <= sel;
        wait_ack(p, !we, exp, name);
    endtask

    task automatic cold_start_quiet();
        for (int c = 0; c < RESET_CYCLES + COLD_CYCLES; c++) begin
            @(posedge Clk);
            if (c == 0) begin
                for (int p = 0; p < NUM_PORTS; p++) begin
                    port_req[p] <= 1'b1;
                    port_we[p] <= 1'b0;
                    port_addr[p] <= ADDR_W'(32'h40 * (p + 1));
                    port_sel[p] <= '1;
                end
            end
            if (c == RESET_CYCLES - 1) begin
                Myreset <= 1'b0;
            end
            @(negedge Clk);
            assert (!wb_cyc_o) else abort_run("Bus cycle started during the cold start");
            assert (port_ack_o == '0) else mismatch("cold_start", 32'h0, 32'(port_ack_o));
        end
    endtask

    task automatic warm_up_gating();
        logic warm_done;
        logic [DATA_W-1:0] exp_data;
        logic [DATA_W-1:0] exp_unc;
        logic [DATA_W-1:0] exp_inst;
        warm_done = 1'b0;
        exp_data = apply_ref(1'b0, 32'h40, '0, '1);
        exp_unc = apply_ref(1'b0, 32'h80, '0, '1);
        exp_inst = apply_ref(1'b0, 32'hc0, '0, '1);
        fork
            begin
                wait_ack(PORT_UNCACHED, 1'b1, exp_unc, "warm_up");
                do_access(PORT_UNCACHED, 1'b0, 32'h84, '0, '1, "warm_up");
                do_access(PORT_UNCACHED, 1'b0, 32'h88, '0, '1, "warm_up");
                warm_done = 1'b1;
            end
            while (!warm_done) begin
                @(negedge Clk);
                assert (!(wb_cyc_o && (wb_adr_o == 32'h40 || wb_adr_o == 32'hc0)))
                    else abort_run("A cached port reached the bus before warm-up ended");
            end
        join
        fork
            wait_ack(PORT_DATA, 1'b1, exp_data, "warm_up data");
            wait_ack(PORT_INST, 1'b1, exp_inst, "warm_up inst");
        join
    endtask

    task automatic write_read_back();
        do_access(PORT_DATA, 1'b1, 32'h100, 32'h1234_5678, 4'hf, "write_read");
        do_access(PORT_DATA, 1'b0, 32'h100, '0, 4'hf, "write_read");
        do_access(PORT_DATA, 1'b1, 32'h100, 32'haabb_ccdd, 4'b0101, "partial_write");
        do_access(PORT_INST, 1'b0, 32'h100, '0, 4'hf, "partial_write");
    endtask

    task automatic priority_order();
        logic [ADDR_W-1:0] exp_order [NUM_PORTS];
        exp_order[PORT_DATA] = 32'h200;
        exp_order[PORT_UNCACHED] = 32'h204;
        exp_order[PORT_INST] = 32'h208;
        bus_log.delete();
        clear_ack_counts();
        @(posedge Clk);
        stall <= 1'b1; // Slave holds off until all three are queued.
        fork
            do_access(PORT_DATA, 1'b0, 32'h200, '0, 4'hf, "priority");
            do_access(PORT_UNCACHED, 1'b1, 32'h204, 32'h0bad_f00d, 4'hf, "priority");
            do_access(PORT_INST, 1'b0, 32'h208, '0, 4'hf, "priority");
            begin
                repeat (STALL_CYCLES) @(posedge Clk);
                stall <= 1'b0;
            end
        join
        repeat (4) @(negedge Clk);
        assert (bus_log.size() == NUM_PORTS)
            else mismatch("priority bus count", NUM_PORTS, bus_log.size());
        for (int i = 0; i < NUM_PORTS; i++) begin
            assert (bus_log[i] == exp_order[i]) else mismatch("priority order", exp_order[i],
                bus_log[i]);
            assert (ack_cnt[i] == 1) else mismatch("priority acks", 1, ack_cnt[i]);
        end
    endtask

    task automatic run_port_ops(input int p);
        for (int i = 0; i < OPS_PER_PORT; i++) begin
            do_access(p, op_we[p][i], op_addr[p][i], op_wdata[p][i], op_sel[p][i],
                "back_pressure");
        end
    endtask

    task automatic back_pressure_mix();
        // Each port gets its own region, so predictions do not depend on bus order.
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int i = 0; i < OPS_PER_PORT; i++) begin
                op_we[p][i] = $random(seed);
                op_addr[p][i] = ADDR_W'((p * 64 + $unsigned($random(seed)) % 16) * 4);
                op_wdata[p][i] = $random(seed);
                op_sel[p][i] = $random(seed);
                if (op_sel[p][i] == '0) begin
                    op_sel[p][i] = '1;
                end
            end
        end
        clear_ack_counts();
        @(posedge Clk);
        rand_wait <= 1'b1;
        fork
            run_port_ops(PORT_DATA);
            run_port_ops(PORT_UNCACHED);
            run_port_ops(PORT_INST);
        join
        repeat (4) @(negedge Clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            assert (ack_cnt[p] == OPS_PER_PORT)
                else mismatch("back_pressure acks", OPS_PER_PORT, ack_cnt[p]);
        end
        rand_wait <= 1'b0;
    endtask

    initial begin
        seed = SEED;
        Myreset = 1'b1;
        port_req = '0;
        port_we = '0;
        port_addr = '0;
        port_wdata = '0;
        port_sel = '0;
        stall = 1'b0;
        rand_wait = 1'b0;
        clear_ack_counts();
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = fill_word(i);
        end
        cold_start_quiet();
        warm_up_gating();
        write_read_back();
        priority_order();
        back_pressure_mix();
        $display("Test OK");
        $finish;
    end

endmodule

/* tb_wb_mem.sv */
`timescale 1ns/1ps

module tb_wb_mem #(
    parameter int MEM_WORDS = 256,
    parameter int MAX_WAIT = 7,
    parameter logic [31:0] SEED = 32'h1
) (
    input logic Clk,
    input logic Myreset,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_we_i,
    input logic [mem_sys_pkg::ADDR_W-1:0] wb_adr_i,
    input logic [mem_sys_pkg::DATA_W-1:0] wb_dat_i,
    input logic [mem_sys_pkg::SEL_W-1:0] wb_sel_i,
    input logic stall_i,
    input logic rand_wait_i,
    output logic [mem_sys_pkg::DATA_W-1:0] wb_dat_o,
    output logic wb_ack_o
);

    import mem_sys_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [DATA_W-1:0] addr_pat;
    logic armed;
    int wait_cnt;
    integer seed;

    assign idx = wb_adr_i[IDX_W+1:2]; // Word addressed.

    initial begin
        seed = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            addr_pat = DATA_W'(i) << 2;
            mem[i] = 32'h5a5a_0000 ^ addr_pat ^ (addr_pat << 16);
        end
    end

    // First cycle of a strobe draws the wait, then counts it down.
    always @(posedge Clk) begin
        if (Myreset) begin
            wb_ack_o <= 1'b0;
            armed <= 1'b0;
            wait_cnt <= 0;
        end else begin
            wb_ack_o <= 1'b0;
            if (wb_cyc_i && wb_stb_i && !wb_ack_o && !stall_i) begin
                if (!armed) begin
                    armed <= 1'b1;
                    wait_cnt <= rand_wait_i ? $unsigned($random(seed)) % (MAX_WAIT + 1) : 0;
                end else if (wait_cnt != 0) begin
                    wait_cnt <= wait_cnt - 1;
                end else begin
                    armed <= 1'b0;
                    wb_ack_o <= 1'b1;
                    wb_dat_o <= mem[idx];
                    if (wb_we_i) begin
                        for (int b = 0; b < SEL_W; b++) begin
                            if (wb_sel_i[b]) begin
                                mem[idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
                            end
                        end
                    end
                end
            end
        end
    end

endmodule

/* warm_up_ctrl.sv */
`timescale 1ns/1ps

module warm_up_ctrl (
    input logic Clk,
    input logic Myreset,
    input logic warm_read_done_i,
    output logic serve_en_o,
    output logic cached_open_o
);

    import mem_sys_pkg::*;

    logic [COLD_CNT_W-1:0] cold_cnt;
    logic [WARM_CNT_W-1:0] warm_cnt;

    // Reset stretch. Nothing is served until the counter wraps.
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            cold_cnt <= '0;
            serve_en_o <= 1'b0;
        end else if (!serve_en_o) begin
            cold_cnt <= cold_cnt + 1'b1;
            if (cold_cnt == COLD_CNT_W'(COLD_CYCLES - 1)) begin
                serve_en_o <= 1'b1;
            end
        end
    end

    // Cached ports stay closed until enough uncached reads came back.
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            warm_cnt <= '0;
            cached_open_o <= 1'b0;
        end else if (warm_read_done_i && !cached_open_o) begin
            warm_cnt <= warm_cnt + 1'b1; // Saturates, since open stops the count.
            if (warm_cnt == WARM_CNT_W'(WARM_READS - 1)) begin
                cached_open_o <= 1'b1;
            end
        end
    end

endmodule

/* wb_master.sv */
`timescale 1ns/1ps

module wb_master (
    input logic Clk,
    input logic Myreset,
    mem_req_if.sink q_wb,
    input logic [mem_sys_pkg::DATA_W-1:0] wb_dat_i,
    input logic wb_ack_i,
    output logic wb_cyc_o,
    output logic wb_stb_o,
    output logic wb_we_o,
    output logic [mem_sys_pkg::ADDR_W-1:0] wb_adr_o,
    output logic [mem_sys_pkg::DATA_W-1:0] wb_dat_o,
    output logic [mem_sys_pkg::SEL_W-1:0] wb_sel_o,
    output logic [mem_sys_pkg::NUM_PORTS-1:0] port_ack_o,
    output logic [mem_sys_pkg::DATA_W-1:0] port_rdata_o,
    output logic warm_read_done_o
);

    import mem_sys_pkg::*;

    typedef enum logic {
        IDLE,
        BUSY
    } state_t;

    state_t state;
    mem_req_t cur_req;

    assign q_wb.ready = (state == IDLE);

    // Classic cycle, one word per request.
    assign wb_cyc_o = (state == BUSY);
    assign wb_stb_o = (state == BUSY);
    assign wb_we_o = cur_req.we;
    assign wb_adr_o = cur_req.addr;
    assign wb_dat_o = cur_req.wdata;
    assign wb_sel_o = cur_req.sel;

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            state <= IDLE;
            port_ack_o <= '0;
            warm_read_done_o <= 1'b0;
        end else begin
            port_ack_o <= '0;
            warm_read_done_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (q_wb.valid) begin
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    if (wb_ack_i) begin
                        state <= IDLE;
                        port_ack_o[cur_req.port] <= 1'b1;
                        warm_read_done_o <= !cur_req.we
                            && (cur_req.port == port_id_t'(PORT_UNCACHED));
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (state == IDLE && q_wb.valid) begin
            cur_req <= q_wb.req;
        end
        if (state == BUSY && wb_ack_i) begin
            port_rdata_o <= wb_dat_i; // Valid with the ack pulse.
        end
    end

endmodule
